// ==== dv/vdp_tb_tasks.svh ====
// ----------------------------------------
// Stimulus helpers
// ----------------------------------------

// Galois LFSR stepped once for every bit taken
function automatic logic [15:0] lfsr_bits(input int n);
  logic [15:0] value;
  value = '0;
  for (int k = 0; k < n; k++) begin
    value  = {value[14:0], lfsr_q[0]};
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
  end
  return value;
endfunction

// One CPU I/O cycle entered right after a falling edge
task automatic bus_access(input vdp_byte_t addr, input vdp_byte_t data, input logic is_write);
  port_addr   = addr;
  cpu_data_in = data;
  iorq_L      = 1'b0;
  wr_L        = !is_write;
  rd_L        = is_write;
  @(negedge clk);
  iorq_L = 1'b1;
  wr_L   = 1'b1;
  rd_L   = 1'b1;
  repeat (BUS_GAP - 1) @(negedge clk);  // Keeps starts BUS_GAP apart
endtask

task automatic ctrl_write(input vdp_byte_t data);
  bus_access(CTRL_PORT_ADDR, data, 1'b1);
endtask

task automatic ctrl_read();
  bus_access(CTRL_PORT_ADDR, 8'h00, 1'b0);
endtask

task automatic data_write(input vdp_byte_t data);
  bus_access(DATA_PORT, data, 1'b1);
  model_mem[model_addr] = data;
  model_addr            = model_addr + 14'd1;
endtask

// Buffer is shown during the access, then refills from the next address
task automatic data_read();
  bus_access(DATA_PORT, 8'h00, 1'b0);
  exp_byte   = model_read(model_addr);
  model_addr = model_addr + 14'd1;
endtask

// ==== dv/vdp_tb.sv ====
`timescale 1ns/1ps

module vdp_tb;

  import vdp_pkg::*;

  localparam vdp_byte_t DATA_PORT    = 8'hBE;
  localparam int        BURST_LEN    = 8;
  localparam int        NUM_ACCESSES = 70;  // All accesses of the sequence below
  localparam int        TIMEOUT_NS   = NUM_ACCESSES * BUS_GAP * 100 * 2;

  logic        clk;
  logic        rst_L;
  logic        iorq_L;
  logic        rd_L;
  logic        wr_L;
  vdp_byte_t   port_addr;
  vdp_byte_t   cpu_data_in;
  vdp_byte_t   cpu_data_out;
  logic        cpu_data_oe;

  // Reference model of VRAM and the address register
  vdp_byte_t   model_mem [vram_addr_t];
  vram_addr_t  model_addr;
  vdp_byte_t   exp_byte;   // Read buffer as the CPU should see it
  logic        data_rd_strobe;
  logic [1:0]  rd_hist;    // Data read strobes of the last two edges
  logic [15:0] lfsr_q;
  int          i;
  vram_addr_t  addr_a;
  vram_addr_t  addr_b;
  vdp_byte_t   byte_a;

  vdp_top dut (
    .clk         (clk),
    .rst_L       (rst_L),
    .iorq_L      (iorq_L),
    .rd_L        (rd_L),
    .wr_L        (wr_L),
    .port_addr   (port_addr),
    .cpu_data_in (cpu_data_in),
    .cpu_data_out(cpu_data_out),
    .cpu_data_oe (cpu_data_oe)
  );

  always #50 clk = ~clk;

  `include "vdp_tb_tasks.svh"

  function automatic vdp_byte_t model_read(input vram_addr_t addr);
    if (model_mem.exists(addr)) begin
      return model_mem[addr];
    end
    return 8'hxx;  // Never written
  endfunction

  // Two control bytes, then the model follows the op
  task automatic send_command(input vram_addr_t addr, input vdp_op_t op);
    ctrl_write(addr[7:0]);
    ctrl_write({op, addr[13:8]});
    if (op == OP_VRAM_READ) begin
      exp_byte   = model_read(addr);  // Prefetch
      model_addr = addr + 14'd1;
    end else if (op == OP_VRAM_WRITE) begin
      model_addr = addr;
    end
  endtask

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  assign data_rd_strobe = !iorq_L && !rd_L && wr_L && (port_addr != CTRL_PORT_ADDR);

  always @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      rd_hist <= 2'b00;
    end else begin
      rd_hist <= {rd_hist[0], data_rd_strobe};
    end
  end

  oe_window: assert property (@(posedge clk) disable iff (!rst_L)
      cpu_data_oe == (rd_hist != 2'b00))
    else begin
      $display("CHECK FAILED: cpu_data_oe exp 0x%0h got 0x%0h",
               $sampled(rd_hist != 2'b00), $sampled(cpu_data_oe));
      $display("Test failed");
      $fatal(1);
    end

  read_data: assert property (@(posedge clk) disable iff (!rst_L)
      cpu_data_oe |-> (cpu_data_out == exp_byte))
    else begin
      $display("CHECK FAILED: cpu_data_out exp 0x%02h got 0x%02h",
               $sampled(exp_byte), $sampled(cpu_data_out));
      $display("Test failed");
      $fatal(1);
    end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    clk         = 1'b0;
    rst_L       = 1'b0;
    iorq_L      = 1'b1;
    rd_L        = 1'b1;
    wr_L        = 1'b1;
    port_addr   = 8'h00;
    cpu_data_in = 8'h00;
    lfsr_q      = 16'd31;
    model_addr  = '0;
    exp_byte    = 8'h00;
    repeat (16) @(negedge clk);
    rst_L = 1'b1;
    @(negedge clk);

    ctrl_read();  // Control reads never drive the bus
    ctrl_read();

    // Burst write, then read back in order
    addr_a = vram_addr_t'(lfsr_bits(14));
    send_command(addr_a, OP_VRAM_WRITE);
    for (i = 0; i < BURST_LEN; i++) data_write(vdp_byte_t'(lfsr_bits(8)));
    send_command(addr_a, OP_VRAM_READ);
    ctrl_read();
    for (i = 0; i < BURST_LEN; i++) data_read();

    // Stale buffer holds the complement of the prefetched byte
    addr_b = vram_addr_t'(lfsr_bits(14));
    byte_a = vdp_byte_t'(lfsr_bits(8));
    send_command(addr_b, OP_VRAM_WRITE);
    data_write(byte_a);
    data_write(~byte_a);
    send_command(addr_b, OP_VRAM_READ);
    data_read();

    // Wrap at the top of VRAM
    send_command(14'h3FFE, OP_VRAM_WRITE);
    for (i = 0; i < 4; i++) data_write(vdp_byte_t'(lfsr_bits(8)));
    send_command(14'h3FFE, OP_VRAM_READ);
    for (i = 0; i < 4; i++) data_read();

    // Register and CRAM ops leave VRAM alone, data writes after them are dropped
    send_command(addr_a, OP_REG_WRITE);
    bus_access(DATA_PORT, ~model_read(addr_a), 1'b1);
    send_command(addr_a, OP_CRAM_WRITE);
    bus_access(DATA_PORT, ~model_read(addr_a), 1'b1);
    send_command(addr_a, OP_VRAM_READ);
    for (i = 0; i < BURST_LEN; i++) data_read();

    // Command restart from write mode, then from read mode
    send_command(addr_b, OP_VRAM_WRITE);
    data_write(vdp_byte_t'(lfsr_bits(8)));
    send_command(addr_a, OP_VRAM_READ);
    data_read();
    data_read();
    send_command(14'h3FFE, OP_VRAM_READ);
    for (i = 0; i < 3; i++) data_read();

    $display("Test completed successfully");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Error: the run timed out before the test sequence ended");
    $display("Test failed");
    $fatal(1);
  end

endmodule : vdp_tb

// ==== flist.f ====
+incdir+dv
verilog/vdp_pkg.sv
verilog/vdp_port_decoder.sv
verilog/vdp_io_fsm.sv
verilog/vdp_io.sv
verilog/vdp_vram.sv
verilog/vdp_top.sv
dv/vdp_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; exit status is pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module vdp_tb -f flist.f -o vdp_sim &&
./obj_dir/vdp_sim || exit 1

// ==== verilog/vdp_io.sv ====
`timescale 1ns/1ps

module vdp_io (
  input  logic                clk,
  input  logic                rst_L,
  input  logic                ctrl_sel,
  input  logic                port_rd,
  input  logic                port_wr,
  input  vdp_pkg::vdp_byte_t  cpu_data_in,
  input  vdp_pkg::vdp_byte_t  vram_rdata,
  output vdp_pkg::vdp_byte_t  cpu_data_out,
  output logic                cpu_data_oe,
  output vdp_pkg::vram_addr_t vram_addr,
  output vdp_pkg::vdp_byte_t  vram_wdata,
  output logic                vram_we,
  output logic                vram_re
);

  import vdp_pkg::*;

  vdp_byte_t  cmd_lo;    // Address 7:0
  vdp_byte_t  cmd_hi;    // Op and address 13:8
  vram_addr_t addr_q;
  vdp_byte_t  data_buf;  // Read prefetch or write data
  vdp_op_t    op;

  logic cmd_lo_en;
  logic cmd_hi_en;
  logic addr_load;
  logic addr_inc;
  logic buf_from_bus;
  logic buf_from_vram;

  assign op = cmd_hi[7:6];

  // ----------------------------------------
  // Command bytes
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (cmd_lo_en) cmd_lo <= cpu_data_in;
    if (cmd_hi_en) cmd_hi <= cpu_data_in;
  end

  // Address wraps naturally at 14 bits
  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      addr_q <= '0;
    end else if (addr_load) begin
      addr_q <= {cmd_hi[5:0], cmd_lo};
    end else if (addr_inc) begin
      addr_q <= addr_q + 14'd1;
    end
  end

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      data_buf <= '0;
    end else if (buf_from_bus) begin
      data_buf <= cpu_data_in;
    end else if (buf_from_vram) begin
      data_buf <= vram_rdata;
    end
  end

  vdp_io_fsm u_fsm (
    .clk          (clk),
    .rst_L        (rst_L),
    .ctrl_sel     (ctrl_sel),
    .port_rd      (port_rd),
    .port_wr      (port_wr),
    .op           (op),
    .cmd_lo_en    (cmd_lo_en),
    .cmd_hi_en    (cmd_hi_en),
    .addr_load    (addr_load),
    .addr_inc     (addr_inc),
    .buf_from_bus (buf_from_bus),
    .buf_from_vram(buf_from_vram),
    .vram_re      (vram_re),
    .vram_we      (vram_we),
    .data_oe      (cpu_data_oe)
  );

  assign vram_addr    = addr_q;
  assign vram_wdata   = data_buf;
  assign cpu_data_out = data_buf;  // Valid while cpu_data_oe

endmodule : vdp_io

// ==== verilog/vdp_io_fsm.sv ====
`timescale 1ns/1ps

module vdp_io_fsm (
  input  logic             clk,
  input  logic             rst_L,
  input  logic             ctrl_sel,
  input  logic             port_rd,
  input  logic             port_wr,
  input  vdp_pkg::vdp_op_t op,
  output logic             cmd_lo_en,
  output logic             cmd_hi_en,
  output logic             addr_load,
  output logic             addr_inc,
  output logic             buf_from_bus,
  output logic             buf_from_vram,
  output logic             vram_re,
  output logic             vram_we,
  output logic             data_oe
);

  import vdp_pkg::*;

  enum logic [3:0] {
    LOAD_LO, LOAD_LO_WAIT, LOAD_HI, LOAD_HI_WAIT, DECODE,
    READ_ADDR, READ_FETCH, READ_CAPTURE, READ_IDLE, READ_GAP,
    WRITE_ADDR, WRITE_IDLE, WRITE_CAPTURE, WRITE_DATA, WRITE_GAP
  } state, next_state;

  logic bus_idle;
  logic ctrl_wr;
  logic data_rd;
  logic data_wr;

  assign bus_idle = !port_rd && !port_wr;
  assign ctrl_wr  = port_wr && ctrl_sel;
  assign data_rd  = port_rd && !ctrl_sel;
  assign data_wr  = port_wr && !ctrl_sel;

  // CPU sees the buffer for the whole data read phase
  assign data_oe = data_rd;

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  always_comb begin
    next_state = state;
    case (state)
      LOAD_LO:      if (ctrl_wr)  next_state = LOAD_LO_WAIT;
      LOAD_LO_WAIT: if (bus_idle) next_state = LOAD_HI;
      LOAD_HI:      if (ctrl_wr)  next_state = LOAD_HI_WAIT;
      LOAD_HI_WAIT: if (bus_idle) next_state = DECODE;
      DECODE: begin
        case (op)
          OP_VRAM_READ:  next_state = READ_ADDR;
          OP_VRAM_WRITE: next_state = WRITE_ADDR;
          default:       next_state = LOAD_LO;  // Register and CRAM ops dropped
        endcase
      end
      READ_ADDR:    next_state = READ_FETCH;
      READ_FETCH:   next_state = READ_CAPTURE;
      READ_CAPTURE: next_state = READ_IDLE;
      READ_IDLE: begin
        if (ctrl_wr) begin
          next_state = LOAD_LO_WAIT;  // New first command byte
        end else if (data_rd) begin
          next_state = READ_GAP;
        end
      end
      READ_GAP:      if (bus_idle) next_state = READ_FETCH;  // Refill after the CPU is done
      WRITE_ADDR:    next_state = WRITE_IDLE;
      WRITE_IDLE: begin
        if (ctrl_wr) begin
          next_state = LOAD_LO_WAIT;
        end else if (data_wr) begin
          next_state = WRITE_CAPTURE;
        end
      end
      WRITE_CAPTURE: next_state = WRITE_DATA;
      WRITE_DATA:    next_state = WRITE_GAP;
      WRITE_GAP:     if (bus_idle) next_state = WRITE_IDLE;
      default:       next_state = LOAD_LO;
    endcase
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------
  always_comb begin
    cmd_lo_en     = 1'b0;
    cmd_hi_en     = 1'b0;
    addr_load     = 1'b0;
    addr_inc      = 1'b0;
    buf_from_bus  = 1'b0;
    buf_from_vram = 1'b0;
    vram_re       = 1'b0;
    vram_we       = 1'b0;
    case (state)
      LOAD_LO:       cmd_lo_en = ctrl_wr;
      LOAD_HI:       cmd_hi_en = ctrl_wr;
      READ_IDLE,
      WRITE_IDLE:    cmd_lo_en = ctrl_wr;  // Command restart from data mode
      READ_ADDR,
      WRITE_ADDR:    addr_load = 1'b1;
      READ_FETCH:    vram_re = 1'b1;
      READ_CAPTURE: begin
        buf_from_vram = 1'b1;
        addr_inc      = 1'b1;
      end
      WRITE_CAPTURE: buf_from_bus = 1'b1;
      WRITE_DATA: begin
        vram_we  = 1'b1;
        addr_inc = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      state <= LOAD_LO;
    end else begin
      state <= next_state;
    end
  end

endmodule : vdp_io_fsm

// ==== verilog/vdp_pkg.sv ====
package vdp_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  typedef logic [7:0]  vdp_byte_t;   // CPU bus byte or VRAM byte
  typedef logic [13:0] vram_addr_t;  // 16K byte address
  typedef logic [1:0]  vdp_op_t;     // Command byte 2 bits 7:6

  // ----------------------------------------
  // Command operations
  // ----------------------------------------
  localparam vdp_op_t OP_VRAM_READ  = 2'd0;
  localparam vdp_op_t OP_VRAM_WRITE = 2'd1;
  localparam vdp_op_t OP_REG_WRITE  = 2'd2;  // Accepted, no effect
  localparam vdp_op_t OP_CRAM_WRITE = 2'd3;  // Accepted, no effect

  // Every other port address is the data port
  localparam vdp_byte_t CTRL_PORT_ADDR = 8'hBF;

  // Minimum clk cycles between the starts of two CPU accesses.
  // Every sequencer action finishes well inside this window.
  localparam int BUS_GAP = 8;

  localparam int VRAM_DEPTH = 16384;

endpackage : vdp_pkg

// ==== verilog/vdp_port_decoder.sv ====
`timescale 1ns/1ps

module vdp_port_decoder (
  input  logic               clk,
  input  logic               rst_L,
  input  logic               iorq_L,
  input  logic               rd_L,
  input  logic               wr_L,
  input  vdp_pkg::vdp_byte_t port_addr,
  output logic               ctrl_sel,
  output logic               port_rd,
  output logic               port_wr
);

  import vdp_pkg::*;

  enum logic [2:0] {
    WAIT = 3'b000,
    RD0  = 3'b001,
    RD1  = 3'b010,
    WR0  = 3'b011,
    WR1  = 3'b100
  } state, next_state;

  // Each access becomes a two cycle phase
  always_comb begin
    next_state = WAIT;
    case (state)
      WAIT: begin
        if (!iorq_L && !wr_L) begin
          next_state = WR0;  // Write wins over read
        end else if (!iorq_L && !rd_L) begin
          next_state = RD0;
        end else begin
          next_state = WAIT;
        end
      end
      RD0:     next_state = RD1;
      RD1:     next_state = WAIT;
      WR0:     next_state = WR1;
      WR1:     next_state = WAIT;
      default: next_state = WAIT;
    endcase
  end

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      state <= WAIT;
    end else begin
      state <= next_state;
    end
  end

  assign port_rd = (state == RD0) || (state == RD1);
  assign port_wr = (state == WR0) || (state == WR1);

  // Port select only meaningful inside a phase
  assign ctrl_sel = (port_rd || port_wr) && (port_addr == CTRL_PORT_ADDR);

endmodule : vdp_port_decoder

// ==== verilog/vdp_top.sv ====
`timescale 1ns/1ps

module vdp_top (
  input  logic               clk,
  input  logic               rst_L,
  input  logic               iorq_L,
  input  logic               rd_L,
  input  logic               wr_L,
  input  vdp_pkg::vdp_byte_t port_addr,
  input  vdp_pkg::vdp_byte_t cpu_data_in,
  output vdp_pkg::vdp_byte_t cpu_data_out,
  output logic               cpu_data_oe
);

  import vdp_pkg::*;

  // Decoder to I/O block
  logic ctrl_sel;
  logic port_rd;
  logic port_wr;

  // I/O block to VRAM
  vram_addr_t vram_addr;
  vdp_byte_t  vram_wdata;
  vdp_byte_t  vram_rdata;
  logic       vram_we;
  logic       vram_re;

  vdp_port_decoder u_decoder (
    .clk      (clk),
    .rst_L    (rst_L),
    .iorq_L   (iorq_L),
    .rd_L     (rd_L),
    .wr_L     (wr_L),
    .port_addr(port_addr),
    .ctrl_sel (ctrl_sel),
    .port_rd  (port_rd),
    .port_wr  (port_wr)
  );

  vdp_io u_io (
    .clk         (clk),
    .rst_L       (rst_L),
    .ctrl_sel    (ctrl_sel),
    .port_rd     (port_rd),
    .port_wr     (port_wr),
    .cpu_data_in (cpu_data_in),
    .vram_rdata  (vram_rdata),
    .cpu_data_out(cpu_data_out),
    .cpu_data_oe (cpu_data_oe),
    .vram_addr   (vram_addr),
    .vram_wdata  (vram_wdata),
    .vram_we     (vram_we),
    .vram_re     (vram_re)
  );

  vdp_vram u_vram (
    .clk  (clk),
    .addr (vram_addr),
    .wdata(vram_wdata),
    .we   (vram_we),
    .re   (vram_re),
    .rdata(vram_rdata)
  );

endmodule : vdp_top

// ==== verilog/vdp_vram.sv ====
`timescale 1ns/1ps

module vdp_vram (
  input  logic                clk,
  input  vdp_pkg::vram_addr_t addr,
  input  vdp_pkg::vdp_byte_t  wdata,
  input  logic                we,
  input  logic                re,
  output vdp_pkg::vdp_byte_t  rdata
);

  import vdp_pkg::*;

  vdp_byte_t mem [VRAM_DEPTH];

  // Single port with one cycle read latency
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    if (re) begin
      rdata <= mem[addr];
    end
  end

endmodule : vdp_vram
